// ==== compile.f ====
design/mmio_pkg.sv
design/mmio_cmd_decoder.sv
design/mmio_apb_requester.sv
design/mmio_controller.sv
design/mmio_resp_framer.sv
design/usb_mmio_top.sv
testbench/usb_mmio_tb.sv

// ==== design/mmio_apb_requester.sv ====
`timescale 1ns/100ps

module mmio_apb_requester (
  input  logic                 clock,
  input  logic                 areset_n,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  logic                 req_write_i,
  input  mmio_pkg::mmio_addr_t req_addr_i,
  input  mmio_pkg::mmio_data_t req_wdata_i,
  output logic                 done_o,
  output mmio_pkg::mmio_data_t done_rdata_o,
  output logic                 done_slverr_o,
  output logic                 psel_o,
  output logic                 penable_o,
  output logic                 pwrite_o,
  output mmio_pkg::mmio_addr_t paddr_o,
  output mmio_pkg::mmio_data_t pwdata_o,
  input  mmio_pkg::mmio_data_t prdata_i,
  input  logic                 pready_i,
  input  logic                 pslverr_i
);

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS
  } apb_state_e;

  apb_state_e           state_q;
  logic                 done_q;
  logic                 write_q;
  logic                 slverr_q;
  mmio_pkg::mmio_addr_t addr_q;
  mmio_pkg::mmio_data_t wdata_q;
  mmio_pkg::mmio_data_t rdata_q;

  assign req_ready_o = (state_q == IDLE);

  assign psel_o    = (state_q != IDLE);
  assign penable_o = (state_q == ACCESS);
  assign pwrite_o  = write_q;
  assign paddr_o   = addr_q;
  assign pwdata_o  = wdata_q;

  assign done_o        = done_q;
  assign done_rdata_o  = rdata_q;
  assign done_slverr_o = slverr_q;

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      state_q <= IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;  // Single-cycle pulse
      case (state_q)
        IDLE:    if (req_valid_i) state_q <= SETUP;
        SETUP:   state_q <= ACCESS;
        ACCESS: begin
          if (pready_i) begin  // Wait states stretch ACCESS
            state_q <= IDLE;
            done_q  <= 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (req_valid_i && req_ready_o) begin
      addr_q  <= req_addr_i;
      wdata_q <= req_wdata_i;
      write_q <= req_write_i;
    end
    if (penable_o && pready_i) begin
      rdata_q  <= prdata_i;
      slverr_q <= pslverr_i;
    end
  end

  a_penable_psel: assert property (
    @(posedge clock) disable iff (!areset_n)
    penable_o |-> psel_o
  );

endmodule

// ==== design/mmio_cmd_decoder.sv ====
`timescale 1ns/100ps

module mmio_cmd_decoder (
  input  logic                clock,
  input  logic                areset_n,
  input  logic                usb_tvalid_i,
  output logic                usb_tready_o,
  input  logic                usb_tlast_i,
  input  mmio_pkg::usb_byte_t usb_tdata_i,
  output logic                cmd_valid_o,
  input  logic                cmd_ready_i,
  output mmio_pkg::mmio_cmd_t cmd_o
);

  typedef enum logic [1:0] {
    RECV,     // Collecting command bytes
    DISCARD,  // Overlong packet, drop bytes until tlast
    HOLD      // Decoded command waits for the controller
  } dec_state_e;

  dec_state_e          state_q;
  mmio_pkg::cmd_idx_t  cnt_q;
  mmio_pkg::mmio_cmd_t cmd_q;
  logic                byte_fire;
  logic                last_idx;
  logic                opcode_ok;

  assign usb_tready_o = (state_q != HOLD);
  assign byte_fire    = usb_tvalid_i && usb_tready_o;
  assign last_idx     = (cnt_q == mmio_pkg::cmd_idx_t'(mmio_pkg::CMD_BYTES - 1));

  assign opcode_ok = (usb_tdata_i == mmio_pkg::OP_SET) ||
                     (usb_tdata_i == mmio_pkg::OP_GET) ||
                     (usb_tdata_i == mmio_pkg::OP_QUERY);

  assign cmd_valid_o = (state_q == HOLD);
  assign cmd_o       = cmd_q;

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      state_q <= RECV;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        RECV: begin
          if (byte_fire) begin
            if (usb_tlast_i) begin
              state_q <= HOLD;  // Complete, or short and already marked bad
              cnt_q   <= '0;
            end else if (last_idx) begin
              state_q <= DISCARD;
              cnt_q   <= '0;
            end else begin
              cnt_q <= cnt_q + 1'b1;
            end
          end
        end
        DISCARD: begin
          if (byte_fire && usb_tlast_i) begin
            state_q <= HOLD;
          end
        end
        HOLD: begin
          if (cmd_ready_i) begin
            state_q <= RECV;
          end
        end
        default: state_q <= RECV;
      endcase
    end
  end

  // Field capture, multi-byte fields arrive MSB first
  always_ff @(posedge clock) begin
    if (byte_fire && state_q == RECV) begin
      case (cnt_q)
        3'd0: begin
          cmd_q.opcode <= usb_tdata_i;
          cmd_q.bad    <= !opcode_ok;  // Fresh flag for each packet
        end
        3'd1:                   cmd_q.tag   <= usb_tdata_i;
        3'd2, 3'd3, 3'd4, 3'd5: cmd_q.addr  <= {cmd_q.addr[23:0], usb_tdata_i};
        default:                cmd_q.wdata <= {cmd_q.wdata[7:0], usb_tdata_i};
      endcase
      // tlast early, or missing on the final byte
      if (usb_tlast_i != last_idx) begin
        cmd_q.bad <= 1'b1;
      end
    end
  end

  a_cmd_stable: assert property (
    @(posedge clock) disable iff (!areset_n)
    cmd_valid_o && !cmd_ready_i |=> cmd_valid_o && $stable(cmd_o)
  );

endmodule

// ==== design/mmio_controller.sv ====
`timescale 1ns/100ps

module mmio_controller (
  input  logic                  clock,
  input  logic                  areset_n,
  input  logic                  cmd_valid_i,
  output logic                  cmd_ready_o,
  input  mmio_pkg::mmio_cmd_t   cmd_i,
  output logic                  req_valid_o,
  input  logic                  req_ready_i,
  output logic                  req_write_o,
  output mmio_pkg::mmio_addr_t  req_addr_o,
  output mmio_pkg::mmio_data_t  req_wdata_o,
  input  logic                  done_i,
  input  mmio_pkg::mmio_data_t  done_rdata_i,
  input  logic                  done_slverr_i,
  output logic                  resp_valid_o,
  input  logic                  resp_ready_i,
  output mmio_pkg::mmio_resp_t  resp_o
);

  typedef enum logic [1:0] {
    IDLE,  // Waiting for a decoded command
    BUS,   // APB transfer in progress
    RESP   // Response offered to the framer
  } ctrl_state_e;

  ctrl_state_e          state_q;
  logic                 issued_q;  // Request already taken by the requester
  logic                 write_q;
  mmio_pkg::mmio_addr_t addr_q;
  mmio_pkg::mmio_data_t wdata_q;
  mmio_pkg::mmio_resp_t resp_q;
  logic                 cmd_fire;
  logic                 no_bus;

  assign cmd_fire = cmd_valid_i && cmd_ready_o;
  // Bad packets and QUERY never reach the bus
  assign no_bus   = cmd_i.bad || (cmd_i.opcode == mmio_pkg::OP_QUERY);

  assign cmd_ready_o  = (state_q == IDLE);
  assign req_valid_o  = (state_q == BUS) && !issued_q;
  assign req_write_o  = write_q;
  assign req_addr_o   = addr_q;
  assign req_wdata_o  = wdata_q;
  assign resp_valid_o = (state_q == RESP);
  assign resp_o       = resp_q;

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      state_q  <= IDLE;
      issued_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          issued_q <= 1'b0;
          if (cmd_valid_i) state_q <= no_bus ? RESP : BUS;
        end
        BUS: begin
          if (req_valid_o && req_ready_i) issued_q <= 1'b1;
          if (done_i) state_q <= RESP;
        end
        RESP:    if (resp_ready_i) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (cmd_fire) begin
      write_q     <= (cmd_i.opcode == mmio_pkg::OP_SET);
      addr_q      <= cmd_i.addr;
      wdata_q     <= cmd_i.wdata;
      resp_q.tag  <= cmd_i.tag;
      resp_q.rdata <= '0;  // SET and bad commands return zero
      if (cmd_i.bad) begin
        resp_q.status <= mmio_pkg::ST_BADCMD;
      end else begin
        resp_q.status <= mmio_pkg::ST_OK;
        if (cmd_i.opcode == mmio_pkg::OP_QUERY) resp_q.rdata <= mmio_pkg::DEVICE_ID;
      end
    end
    if (done_i && state_q == BUS) begin
      resp_q.status <= done_slverr_i ? mmio_pkg::ST_SLVERR : mmio_pkg::ST_OK;
      resp_q.rdata  <= write_q ? '0 : done_rdata_i;
    end
  end

  // One command in flight at a time
  a_single_cmd: assert property (
    @(posedge clock) disable iff (!areset_n)
    cmd_fire |=> !cmd_ready_o
  );

endmodule

// ==== design/mmio_pkg.sv ====
package mmio_pkg;

  // Packet lengths, in bytes
  localparam int unsigned CMD_BYTES  = 8;
  localparam int unsigned RESP_BYTES = 4;

  // Stream and bus widths
  typedef logic [7:0]  usb_byte_t;
  typedef logic [31:0] mmio_addr_t;  // APB byte address
  typedef logic [15:0] mmio_data_t;  // Register data
  typedef logic [7:0]  mmio_tag_t;   // Echoed back in the response

  // Byte positions within a packet
  typedef logic [$clog2(CMD_BYTES)-1:0]  cmd_idx_t;
  typedef logic [$clog2(RESP_BYTES)-1:0] resp_idx_t;

  // Identifier returned by QUERY
  localparam mmio_data_t DEVICE_ID = 16'h4D31;

  // Command byte, anything else is rejected
  typedef enum logic [7:0] {
    OP_SET   = 8'h01,  // APB write
    OP_GET   = 8'h02,  // APB read
    OP_QUERY = 8'h03   // Device identifier, no bus access
  } mmio_opcode_e;

  // Response status byte
  typedef enum logic [7:0] {
    ST_OK     = 8'h00,
    ST_SLVERR = 8'h01,  // pslverr seen on the transfer
    ST_BADCMD = 8'h02   // Malformed packet or unknown opcode
  } mmio_status_e;

  // Decoded command, as held by the decoder
  typedef struct packed {
    usb_byte_t  opcode;  // Raw byte, may hold an unknown code
    mmio_tag_t  tag;
    mmio_addr_t addr;
    mmio_data_t wdata;
    logic       bad;     // Length or opcode check failed
  } mmio_cmd_t;

  // Status packet contents, serialised in field order
  typedef struct packed {
    mmio_tag_t    tag;
    mmio_status_e status;
    mmio_data_t   rdata;
  } mmio_resp_t;

endpackage

// ==== design/mmio_resp_framer.sv ====
`timescale 1ns/100ps

module mmio_resp_framer (
  input  logic                 clock,
  input  logic                 areset_n,
  input  logic                 resp_valid_i,
  output logic                 resp_ready_o,
  input  mmio_pkg::mmio_resp_t resp_i,
  output logic                 usb_tvalid_o,
  input  logic                 usb_tready_i,
  output logic                 usb_tlast_o,
  output mmio_pkg::usb_byte_t  usb_tdata_o
);

  logic                 busy_q;  // Packet being sent
  mmio_pkg::resp_idx_t  idx_q;
  mmio_pkg::mmio_resp_t resp_q;
  logic                 byte_fire;

  // New response only once the previous packet is out
  assign resp_ready_o = !busy_q;
  assign usb_tvalid_o = busy_q;
  assign byte_fire    = usb_tvalid_o && usb_tready_i;
  assign usb_tlast_o  = (idx_q == mmio_pkg::resp_idx_t'(mmio_pkg::RESP_BYTES - 1));

  // Byte order is tag, status, rdata high, rdata low
  always_comb begin
    case (idx_q)
      2'd0:    usb_tdata_o = resp_q.tag;
      2'd1:    usb_tdata_o = resp_q.status;
      2'd2:    usb_tdata_o = resp_q.rdata[15:8];
      default: usb_tdata_o = resp_q.rdata[7:0];
    endcase
  end

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      busy_q <= 1'b0;
      idx_q  <= '0;
    end else begin
      if (resp_valid_i && resp_ready_o) begin
        busy_q <= 1'b1;
        idx_q  <= '0;
      end else if (byte_fire) begin
        if (usb_tlast_o) begin
          busy_q <= 1'b0;
          idx_q  <= '0;
        end else begin
          idx_q <= idx_q + 1'b1;
        end
      end
    end
  end

  // Payload held for the whole packet
  always_ff @(posedge clock) begin
    if (resp_valid_i && resp_ready_o) begin
      resp_q <= resp_i;
    end
  end

  a_tdata_stable: assert property (
    @(posedge clock) disable iff (!areset_n)
    usb_tvalid_o && !usb_tready_i |=>
      usb_tvalid_o && $stable(usb_tdata_o) && $stable(usb_tlast_o)
  );

endmodule

// ==== design/usb_mmio_top.sv ====
`timescale 1ns/100ps

module usb_mmio_top (
  input  logic                 clock,
  input  logic                 areset_n,
  // Bulk OUT, command packets
  input  logic                 usb_tvalid_i,
  output logic                 usb_tready_o,
  input  logic                 usb_tlast_i,
  input  mmio_pkg::usb_byte_t  usb_tdata_i,
  // Bulk IN, status packets
  output logic                 usb_tvalid_o,
  input  logic                 usb_tready_i,
  output logic                 usb_tlast_o,
  output mmio_pkg::usb_byte_t  usb_tdata_o,
  // APB requester
  output logic                 psel_o,
  output logic                 penable_o,
  output logic                 pwrite_o,
  output mmio_pkg::mmio_addr_t paddr_o,
  output mmio_pkg::mmio_data_t pwdata_o,
  input  mmio_pkg::mmio_data_t prdata_i,
  input  logic                 pready_i,
  input  logic                 pslverr_i
);

  logic                 cmd_valid;
  logic                 cmd_ready;
  mmio_pkg::mmio_cmd_t  cmd;
  logic                 req_valid;
  logic                 req_ready;
  logic                 req_write;
  mmio_pkg::mmio_addr_t req_addr;
  mmio_pkg::mmio_data_t req_wdata;
  logic                 done;
  logic                 done_slverr;
  mmio_pkg::mmio_data_t done_rdata;
  logic                 resp_valid;
  logic                 resp_ready;
  mmio_pkg::mmio_resp_t resp;

  mmio_cmd_decoder u_decoder (
    .clock        (clock),
    .areset_n     (areset_n),
    .usb_tvalid_i (usb_tvalid_i),
    .usb_tready_o (usb_tready_o),
    .usb_tlast_i  (usb_tlast_i),
    .usb_tdata_i  (usb_tdata_i),
    .cmd_valid_o  (cmd_valid),
    .cmd_ready_i  (cmd_ready),
    .cmd_o        (cmd)
  );

  mmio_controller u_controller (
    .clock         (clock),
    .areset_n      (areset_n),
    .cmd_valid_i   (cmd_valid),
    .cmd_ready_o   (cmd_ready),
    .cmd_i         (cmd),
    .req_valid_o   (req_valid),
    .req_ready_i   (req_ready),
    .req_write_o   (req_write),
    .req_addr_o    (req_addr),
    .req_wdata_o   (req_wdata),
    .done_i        (done),
    .done_rdata_i  (done_rdata),
    .done_slverr_i (done_slverr),
    .resp_valid_o  (resp_valid),
    .resp_ready_i  (resp_ready),
    .resp_o        (resp)
  );

  mmio_apb_requester u_requester (
    .clock         (clock),
    .areset_n      (areset_n),
    .req_valid_i   (req_valid),
    .req_ready_o   (req_ready),
    .req_write_i   (req_write),
    .req_addr_i    (req_addr),
    .req_wdata_i   (req_wdata),
    .done_o        (done),
    .done_rdata_o  (done_rdata),
    .done_slverr_o (done_slverr),
    .psel_o        (psel_o),
    .penable_o     (penable_o),
    .pwrite_o      (pwrite_o),
    .paddr_o       (paddr_o),
    .pwdata_o      (pwdata_o),
    .prdata_i      (prdata_i),
    .pready_i      (pready_i),
    .pslverr_i     (pslverr_i)
  );

  mmio_resp_framer u_framer (
    .clock        (clock),
    .areset_n     (areset_n),
    .resp_valid_i (resp_valid),
    .resp_ready_o (resp_ready),
    .resp_i       (resp),
    .usb_tvalid_o (usb_tvalid_o),
    .usb_tready_i (usb_tready_i),
    .usb_tlast_o  (usb_tlast_o),
    .usb_tdata_o  (usb_tdata_o)
  );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module usb_mmio_tb -f compile.f -o usb_mmio_sim
./obj_dir/usb_mmio_sim > sim.log 2>&1
cat sim.log
if grep -q "Something failed" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
echo "Simulation finished without failures"

// ==== testbench/usb_mmio_tb.sv ====
`timescale 1ns/100ps

module usb_mmio_tb;

  localparam int  NUM_ROWS   = 12;
  localparam time CLK_PERIOD = 4;

  typedef struct packed {
    logic [0:9][7:0] bytes;     // Packet bytes in send order
    logic [3:0]      len;
    logic [3:0]      last_pos;  // Byte that carries tlast
    logic [7:0]      status;    // Expected status
  } cmd_row_t;

  logic        clock;
  logic        areset_n;
  logic        usb_tvalid_i;
  logic        usb_tready_o;
  logic        usb_tlast_i;
  logic [7:0]  usb_tdata_i;
  logic        usb_tvalid_o;
  logic        usb_tready_i;
  logic        usb_tlast_o;
  logic [7:0]  usb_tdata_o;
  logic        psel_o;
  logic        penable_o;
  logic        pwrite_o;
  logic [31:0] paddr_o;
  logic [15:0] pwdata_o;
  logic [15:0] prdata_i;
  logic        pready_i;
  logic        pslverr_i;

  cmd_row_t    rows [NUM_ROWS];
  logic [15:0] mem [16];
  logic [15:0] shadow [16];  // What the slave memory should hold
  logic [31:0] stim_rand;
  logic [31:0] exp_paddr;    // Bus request expected for the current row
  logic        exp_pwrite;
  logic [15:0] exp_pwdata;
  int          apb_setups;
  int          mismatches;
  int          failures;

  usb_mmio_top dut0 (.*);

  function automatic logic [15:0] next_rand(inout logic [31:0] state);
    state = state * 32'd1103515245 + 32'd12345;
    return state[31:16];
  endfunction

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  // APB slave with 0 to 3 wait states and pslverr for top address nibble Fh
  initial begin
    logic [31:0] apb_rand;
    int          wait_left;
    int          k;
    apb_rand   = 32'd78676;
    wait_left  = 0;
    apb_setups = 0;
    {pready_i, pslverr_i, prdata_i} = '0;
    for (k = 0; k < 16; k++) mem[k] = {4'(k), ~4'(k), 4'(k) ^ 4'h5, 4'hA};
    forever begin
      @(posedge clock);
      #1;
      pready_i = 1'b0;
      if (psel_o && !penable_o) begin
        apb_setups++;  // Setup phase seen
        wait_left = int'(next_rand(apb_rand) % 16'd4);
        if (paddr_o !== exp_paddr) begin
          $display("Mismatch APB setup: paddr_o got %h expected %h", paddr_o, exp_paddr);
          mismatches++;
        end
        if (pwrite_o !== exp_pwrite) begin
          $display("Mismatch APB setup: pwrite_o got %h expected %h", pwrite_o, exp_pwrite);
          mismatches++;
        end
        if (exp_pwrite && pwdata_o !== exp_pwdata) begin
          $display("Mismatch APB setup: pwdata_o got %h expected %h",
                   pwdata_o, exp_pwdata);
          mismatches++;
        end
      end else if (psel_o && penable_o) begin
        if (wait_left == 0) begin
          pready_i  = 1'b1;
          pslverr_i = (paddr_o[31:28] == 4'hF);
          prdata_i  = mem[paddr_o[5:2]];
          if (pwrite_o && !pslverr_i) mem[paddr_o[5:2]] = pwdata_o;
        end else begin
          wait_left--;
        end
      end
    end
  end

  task automatic send_packet(input cmd_row_t row);
    int   i;
    logic taken;
    for (i = 0; i < int'(row.len); i++) begin
      while (next_rand(stim_rand) % 16'd4 == 16'd0) begin  // Idle gap before the byte
        usb_tvalid_i = 1'b0;
        @(posedge clock);
        #1;
      end
      usb_tvalid_i = 1'b1;
      usb_tdata_i  = row.bytes[i];
      usb_tlast_i  = (i == int'(row.last_pos));
      taken        = 1'b0;
      while (!taken) begin
        taken = usb_tready_o;  // Held until the next edge
        @(posedge clock);
        #1;
      end
    end
    {usb_tvalid_i, usb_tlast_i} = '0;
  endtask

  task automatic receive_packet(input int row, output logic [0:3][7:0] got);
    int k;
    k = 0;
    while (k < 4) begin
      usb_tready_i = (next_rand(stim_rand) % 16'd4 != 16'd0);  // Random stalls
      if (usb_tvalid_o && usb_tready_i) begin
        got[k] = usb_tdata_o;
        if (usb_tlast_o !== (k == 3)) begin
          $display("Mismatch row %0d byte %0d: usb_tlast_o got %h expected %h",
                   row, k, usb_tlast_o, k == 3);
          mismatches++;
        end
        k++;
      end
      @(posedge clock);
      #1;
    end
    usb_tready_i = 1'b0;
  endtask

  // Watchdog allows 200 cycles per command row
  initial begin
    #(NUM_ROWS * 200 * CLK_PERIOD);
    $display("Timeout: the test did not finish within %0d cycles", NUM_ROWS * 200);
    $display("Something failed");
    $finish;
  end

  initial begin
    int              r;
    int              k;
    int              setups_before;
    logic            is_bus;
    logic [7:0]      op;
    logic [31:0]     addr;
    logic [15:0]     exp_rdata;
    logic [0:3][7:0] got;
    logic [0:3][7:0] exp_bytes;
    stim_rand  = 32'd78676;
    mismatches = 0;
    failures   = 0;
    areset_n   = 1'b0;
    {usb_tvalid_i, usb_tlast_i, usb_tdata_i, usb_tready_i} = '0;
    for (k = 0; k < 16; k++) shadow[k] = {4'(k), ~4'(k), 4'(k) ^ 4'h5, 4'hA};
    // opcode, tag, address, wdata, filler | length | tlast byte | status
    // Status 00 ok, 01 slave error, 02 bad command
    rows[0]  = '{{8'h01, 8'h10, 32'h0000_0010, 16'hBEEF, 16'h0}, 4'd8, 4'd7, 8'h00};
    rows[1]  = '{{8'h02, 8'h11, 32'h0000_0010, 16'h0000, 16'h0}, 4'd8, 4'd7, 8'h00};
    rows[2]  = '{{8'h03, 8'h12, 32'h0000_0000, 16'h0000, 16'h0}, 4'd8, 4'd7, 8'h00};
    rows[3]  = '{{8'h01, 8'h13, 32'hF000_0004, 16'h1234, 16'h0}, 4'd8, 4'd7, 8'h01};
    rows[4]  = '{{8'h02, 8'h14, 32'hF000_0004, 16'h0000, 16'h0}, 4'd8, 4'd7, 8'h01};
    rows[5]  = '{{8'h7A, 8'h15, 32'h0000_0010, 16'h5555, 16'h0}, 4'd8, 4'd7, 8'h02};
    rows[6]  = '{{8'h02, 8'h16, 32'h0000_0010, 16'h0000, 16'h0}, 4'd8, 4'd7, 8'h00};
    rows[7]  = '{{8'h01, 8'h17, 32'h0000_0030, 16'h7777, 16'h0}, 4'd4, 4'd3, 8'h02};
    rows[8]  = '{{8'h01, 8'h18, 32'h0000_0024, 16'h5A5A, 16'h0}, 4'd8, 4'd7, 8'h00};
    rows[9]  = '{{8'h02, 8'h19, 32'h0000_0024, 16'h0000, 16'hEEEE}, 4'd10, 4'd9, 8'h02};
    rows[10] = '{{8'h02, 8'h1A, 32'h0000_0024, 16'h0000, 16'h0}, 4'd8, 4'd7, 8'h00};
    rows[11] = '{{8'h03, 8'h1B, 32'h0000_0000, 16'h0000, 16'h0}, 4'd8, 4'd7, 8'h00};
    repeat (3) @(posedge clock);
    #1;
    if ({usb_tvalid_o, psel_o, penable_o, usb_tready_o} !== 4'h1) begin
      $display(
        "Mismatch after reset: usb_tvalid_o psel_o penable_o usb_tready_o got %h expected 1",
        {usb_tvalid_o, psel_o, penable_o, usb_tready_o});
      mismatches++;
    end
    areset_n = 1'b1;
    for (r = 0; r < NUM_ROWS; r++) begin
      op            = rows[r].bytes[0];
      addr          = rows[r].bytes[2:5];
      exp_paddr     = addr;
      exp_pwrite    = (op == 8'h01);  // SET writes, GET reads
      exp_pwdata    = rows[r].bytes[6:7];
      setups_before = apb_setups;
      send_packet(rows[r]);
      receive_packet(r, got);
      exp_rdata = '0;  // SET and bad commands
      is_bus    = (rows[r].status != 8'h02) && (op != 8'h03);
      if (rows[r].status != 8'h02 && op == 8'h03) exp_rdata = 16'h4D31;
      if (is_bus && op == 8'h02) exp_rdata = shadow[addr[5:2]];
      if (is_bus && op == 8'h01 && rows[r].status == 8'h00) begin
        shadow[addr[5:2]] = rows[r].bytes[6:7];
      end
      exp_bytes = {rows[r].bytes[1], rows[r].status, exp_rdata};
      for (k = 0; k < 4; k++) begin
        if (got[k] !== exp_bytes[k]) begin
          $display("Mismatch row %0d byte %0d: usb_tdata_o got %h expected %h",
                   r, k, got[k], exp_bytes[k]);
          mismatches++;
        end
      end
      if (apb_setups - setups_before != (is_bus ? 1 : 0)) begin
        $display("Row %0d: %0d APB transfers ran where %0d should have",
                 r, apb_setups - setups_before, is_bus ? 1 : 0);
        failures++;
      end
    end
    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
